// File: filelist.f
+incdir+.
cc_pkg.sv
cc_spill_reg.sv
offload_decode.sv
ssr_cfg_regs.sv
offload_resp_arbiter.sv
data_port_router.sv
core_complex.sv
tb_core_complex.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the core complex testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_core_complex -f filelist.f -o sim_core_complex || exit 1

out="$(./obj_dir/sim_core_complex 2>&1)"
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1

// File: tb_core_complex.sv
// -------------------------------------
// Core complex testbench
// Offload and data port traffic with
// port models and in-order checking
// -------------------------------------
`timescale 1ns/100ps
`include "cc_consts.svh"

module tb_core_complex;

  import cc_pkg::*;

  localparam int unsigned NumOff  = 120;
  localparam int unsigned NumData = 150;
  // Directed offloads: 16 reads, 16 write/read pairs, 2 stray writes, 16 re-reads
  localparam int unsigned NumOps  = 66 + NumOff + NumData;
  localparam int unsigned Limit   = NumOps * 40;
  localparam logic [31:0] TcdmBase = 32'h1000_0000;
  localparam logic [31:0] TcdmMask = 32'hFFFF_F000;

  logic clk_i = 1'b0;
  logic rst_ni;
  acc_req_t acc_req_i;
  logic acc_req_valid_i, acc_req_ready_o;
  acc_rsp_t acc_rsp_o;
  logic acc_rsp_valid_o, acc_rsp_ready_i;
  acc_req_t ext_req_o;
  logic ext_req_valid_o, ext_req_ready_i;
  acc_rsp_t ext_rsp_i;
  logic ext_rsp_valid_i, ext_rsp_ready_o;
  logic [31:0] tcdm_base_i;
  dreq_t data_req_i, tcdm_req_o, soc_req_o;
  logic data_req_valid_i, data_req_ready_o;
  drsp_t data_rsp_o, tcdm_rsp_i, soc_rsp_i;
  logic data_rsp_valid_o, data_rsp_ready_i;
  logic tcdm_valid_o, tcdm_ready_i, tcdm_rsp_valid_i, tcdm_rsp_ready_o;
  logic soc_valid_o, soc_ready_i, soc_rsp_valid_i, soc_rsp_ready_o;

  // Expected streams and port model queues
  acc_req_t ext_req_exp[$];
  acc_rsp_t ext_rsp_exp[$], cfg_rsp_exp[$], ext_pend[$];
  dreq_t tcdm_req_exp[$], soc_req_exp[$];
  drsp_t data_exp[$], tcdm_pend[$], soc_pend[$];
  int ext_due[$], tcdm_due[$], soc_due[$];
  logic [31:0] ref_regs[`CC_NUM_SSRS*`CC_SSR_NUM_REGS];
  int cycle = 0;

  always #2 clk_i = ~clk_i;

  core_complex UUT (.*);

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  // ------------------------------------
  // Reference models
  // ------------------------------------
  function automatic logic [31:0] cfg_ref(input logic [11:0] word, input logic write,
                                          input logic [31:0] wdata);
    int idx;
    logic ok;
    logic [31:0] old;
    ok  = (word[4:0] < `CC_NUM_SSRS) && (word[11:5] < `CC_SSR_NUM_REGS);
    idx = int'(word[11:5]) * `CC_NUM_SSRS + int'(word[4:0]);
    old = ok ? ref_regs[idx] : 32'h0;
    if (ok && write) ref_regs[idx] = wdata;
    return old;
  endfunction

  function automatic logic in_tcdm_window(input logic [31:0] addr);
    return (addr & TcdmMask) == TcdmBase;
  endfunction

  // Memory contents depend on the whole address
  function automatic drsp_t tcdm_word(input dreq_t r);
    return '{data: r.addr ^ 32'h5A5A_0F0F, error: 1'b0};
  endfunction

  function automatic drsp_t soc_word(input dreq_t r);
    return '{data: {r.addr[15:0], r.addr[31:16]} ^ 32'hC3C3_3C3C,
             error: r.write & r.addr[3]};
  endfunction

  function automatic drsp_t mem_ref(input dreq_t r);
    return in_tcdm_window(r.addr) ? tcdm_word(r) : soc_word(r);
  endfunction

  // ------------------------------------
  // Stimulus
  // ------------------------------------
  task automatic send_acc(input acc_req_t r);
    @(negedge clk_i);
    acc_req_i = r;
    acc_req_valid_i = 1'b1;
    do @(posedge clk_i); while (!acc_req_ready_o);
  endtask

  task automatic cfg_access(input logic write, input logic imm, input logic [11:0] word,
                            input logic [4:0] id, input logic [31:0] wdata);
    acc_req_t r;
    logic [31:0] opc;
    opc = write ? (imm ? `CC_OP_SCFGWI : `CC_OP_SCFGW) : (imm ? `CC_OP_SCFGRI : `CC_OP_SCFGR);
    r.addr      = 1'b1;
    r.id        = id;
    r.data_arga = wdata;
    r.data_op   = imm ? ({word, 20'h0} | opc) : (($urandom & ~`CC_OP_MASK) | opc);
    r.data_argb = imm ? $urandom : {20'($urandom), word};
    cfg_rsp_exp.push_back(acc_rsp_t'{id: write ? 5'd0 : id,
                                     data: cfg_ref(word, write, wdata),
                                     error: 1'b0});
    send_acc(r);
  endtask

  task automatic ext_access();
    acc_req_t r;
    r.addr      = 1'b0;
    r.id        = 5'd16 + 5'($urandom % 16);
    r.data_op   = $urandom;
    r.data_arga = $urandom;
    r.data_argb = $urandom;
    ext_req_exp.push_back(r);
    ext_rsp_exp.push_back(acc_rsp_t'{id: r.id, data: r.data_arga + r.data_argb,
                                     error: r.data_argb[0]});
    send_acc(r);
  endtask

  task automatic offload_stream();
    logic [11:0] word;
    for (int w = 0; w < 16; w++) cfg_access(1'b0, 1'b1, {7'(w / 2), 5'(w % 2)}, 5'd1, 32'h0);
    for (int w = 0; w < 16; w++) begin
      word = {7'(w / 2), 5'(w % 2)};
      cfg_access(1'b1, 1'b1, word, 5'd3, $urandom);
      cfg_access(1'b0, 1'b0, word, 5'(w % 15 + 1), 32'h0);
    end
    // Out of range in both fields
    cfg_access(1'b1, 1'b0, {7'd9, 5'd0}, 5'd2, $urandom);
    cfg_access(1'b1, 1'b1, {7'd0, 5'd3}, 5'd2, $urandom);
    // Every register must still hold its earlier value
    for (int w = 0; w < 16; w++) begin
      cfg_access(1'b0, 1'(w % 2), {7'(w / 2), 5'(w % 2)}, 5'(w % 15 + 1), 32'h0);
    end
    for (int i = 0; i < NumOff; i++) begin
      if ($urandom % 8 == 0) word = {7'($urandom % 16), 5'($urandom % 4)};
      else word = {7'($urandom % 8), 5'($urandom % 2)};
      case ($urandom % 3)
        0: ext_access();
        1: cfg_access(1'b1, 1'($urandom), word, 5'd7, $urandom);
        default: cfg_access(1'b0, 1'($urandom), word, 5'($urandom % 15 + 1), 32'h0);
      endcase
    end
    @(negedge clk_i);
    acc_req_valid_i = 1'b0;
  endtask

  task automatic data_stream();
    dreq_t r;
    for (int i = 0; i < NumData; i++) begin
      r.addr  = ($urandom % 2) ? (TcdmBase | ($urandom & 32'hFFF)) : $urandom;
      r.write = 1'($urandom);
      r.data  = $urandom;
      r.strb  = 4'($urandom);
      if (in_tcdm_window(r.addr)) tcdm_req_exp.push_back(r);
      else soc_req_exp.push_back(r);
      data_exp.push_back(mem_ref(r));
      @(negedge clk_i);
      data_req_i = r;
      data_req_valid_i = 1'b1;
      do @(posedge clk_i); while (!data_req_ready_o);
    end
    @(negedge clk_i);
    data_req_valid_i = 1'b0;
  endtask

  // ------------------------------------
  // Port models drive on the falling edge
  // ------------------------------------
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      ext_req_ready_i  = ($urandom % 4) != 0;
      tcdm_ready_i     = ($urandom % 4) != 0;
      soc_ready_i      = ($urandom % 3) != 0;
      acc_rsp_ready_i  = ($urandom % 3) != 0;
      data_rsp_ready_i = ($urandom % 3) != 0;
      ext_rsp_valid_i  = (ext_pend.size() > 0) && (cycle >= ext_due[0]);
      if (ext_rsp_valid_i) ext_rsp_i = ext_pend[0];
      tcdm_rsp_valid_i = (tcdm_pend.size() > 0) && (cycle >= tcdm_due[0]);
      if (tcdm_rsp_valid_i) tcdm_rsp_i = tcdm_pend[0];
      soc_rsp_valid_i  = (soc_pend.size() > 0) && (cycle >= soc_due[0]);
      if (soc_rsp_valid_i) soc_rsp_i = soc_pend[0];
    end
  end

  // ------------------------------------
  // Compare process
  // ------------------------------------
  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle > Limit) fail_stop("Timeout: the run did not finish within the cycle limit");
    if (!rst_ni && ext_req_valid_o && ext_req_ready_i) begin
      assert (ext_req_exp.size() > 0) else fail_stop("Unexpected request on the ext port");
      assert (ext_req_o == ext_req_exp[0])
        else fail_stop($sformatf("[FAIL] ext_req_o got %h expected %h", ext_req_o,
                                 ext_req_exp[0]));
      void'(ext_req_exp.pop_front());
      ext_pend.push_back(acc_rsp_t'{id: ext_req_o.id,
                                    data: ext_req_o.data_arga + ext_req_o.data_argb,
                                    error: ext_req_o.data_argb[0]});
      ext_due.push_back(cycle + 1 + int'($urandom % 6));
    end
    if (!rst_ni && tcdm_valid_o && tcdm_ready_i) begin
      assert (tcdm_req_exp.size() > 0) else fail_stop("Unexpected request on the TCDM port");
      assert (tcdm_req_o == tcdm_req_exp[0])
        else fail_stop($sformatf("[FAIL] tcdm_req_o got %h expected %h", tcdm_req_o,
                                 tcdm_req_exp[0]));
      void'(tcdm_req_exp.pop_front());
      tcdm_pend.push_back(tcdm_word(tcdm_req_o));
      tcdm_due.push_back(cycle + 1 + int'($urandom % 8));
    end
    if (!rst_ni && soc_valid_o && soc_ready_i) begin
      assert (soc_req_exp.size() > 0) else fail_stop("Unexpected request on the SoC port");
      assert (soc_req_o == soc_req_exp[0])
        else fail_stop($sformatf("[FAIL] soc_req_o got %h expected %h", soc_req_o,
                                 soc_req_exp[0]));
      void'(soc_req_exp.pop_front());
      soc_pend.push_back(soc_word(soc_req_o));
      soc_due.push_back(cycle + 1 + int'($urandom % 8));
    end
    if (ext_rsp_valid_i && ext_rsp_ready_o) begin
      void'(ext_pend.pop_front());
      void'(ext_due.pop_front());
    end
    if (tcdm_rsp_valid_i && tcdm_rsp_ready_o) begin
      void'(tcdm_pend.pop_front());
      void'(tcdm_due.pop_front());
    end
    if (soc_rsp_valid_i && soc_rsp_ready_o) begin
      void'(soc_pend.pop_front());
      void'(soc_due.pop_front());
    end
    if (!rst_ni && acc_rsp_valid_o && acc_rsp_ready_i) begin
      // Ext ids live in the upper half
      if (acc_rsp_o.id[4]) begin
        assert (ext_rsp_exp.size() > 0) else fail_stop("Extra ext response on the offload port");
        assert (acc_rsp_o == ext_rsp_exp[0])
          else fail_stop($sformatf("[FAIL] acc_rsp_o got %h expected %h", acc_rsp_o,
                                   ext_rsp_exp[0]));
        void'(ext_rsp_exp.pop_front());
      end else begin
        assert (cfg_rsp_exp.size() > 0) else fail_stop("Extra config answer on the offload port");
        assert (acc_rsp_o == cfg_rsp_exp[0])
          else fail_stop($sformatf("[FAIL] acc_rsp_o got %h expected %h", acc_rsp_o,
                                   cfg_rsp_exp[0]));
        void'(cfg_rsp_exp.pop_front());
      end
    end
    if (!rst_ni && data_rsp_valid_o && data_rsp_ready_i) begin
      assert (data_exp.size() > 0) else fail_stop("Extra response on the data port");
      assert (data_rsp_o == data_exp[0])
        else fail_stop($sformatf("[FAIL] data_rsp_o got %h expected %h", data_rsp_o,
                                 data_exp[0]));
      void'(data_exp.pop_front());
    end
  end

  initial begin
    void'($urandom(32'h4143cabc));
    foreach (ref_regs[i]) ref_regs[i] = 32'h0;
    rst_ni = 1'b1;
    tcdm_base_i = TcdmBase;
    acc_req_i = '0;
    acc_req_valid_i = 1'b0;
    acc_rsp_ready_i = 1'b0;
    ext_req_ready_i = 1'b0;
    ext_rsp_i = '0;
    ext_rsp_valid_i = 1'b0;
    data_req_i = '0;
    data_req_valid_i = 1'b0;
    data_rsp_ready_i = 1'b0;
    tcdm_ready_i = 1'b0;
    tcdm_rsp_i = '0;
    tcdm_rsp_valid_i = 1'b0;
    soc_ready_i = 1'b0;
    soc_rsp_i = '0;
    soc_rsp_valid_i = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b0;
    assert (!acc_rsp_valid_o && !ext_req_valid_o && !tcdm_valid_o && !soc_valid_o)
      else fail_stop("A valid output is high right after reset");
    fork
      offload_stream();
      data_stream();
    join
    while (ext_rsp_exp.size() + cfg_rsp_exp.size() + data_exp.size() > 0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: core_complex.sv
// -------------------------------------
// Core complex top level
// Offload path with SSR config target,
// and the core data port router
// -------------------------------------
`timescale 1ns/100ps
`include "cc_consts.svh"

module core_complex (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Offload port from the core
  input  cc_pkg::acc_req_t          acc_req_i,
  input  logic                      acc_req_valid_i,
  output logic                      acc_req_ready_o,
  output cc_pkg::acc_rsp_t          acc_rsp_o,
  output logic                      acc_rsp_valid_o,
  input  logic                      acc_rsp_ready_i,
  // Shared accelerator
  output cc_pkg::acc_req_t          ext_req_o,
  output logic                      ext_req_valid_o,
  input  logic                      ext_req_ready_i,
  input  cc_pkg::acc_rsp_t          ext_rsp_i,
  input  logic                      ext_rsp_valid_i,
  output logic                      ext_rsp_ready_o,
  // Core data port
  input  logic [`CC_ADDR_WIDTH-1:0] tcdm_base_i,
  input  cc_pkg::dreq_t             data_req_i,
  input  logic                      data_req_valid_i,
  output logic                      data_req_ready_o,
  output cc_pkg::drsp_t             data_rsp_o,
  output logic                      data_rsp_valid_o,
  input  logic                      data_rsp_ready_i,
  output cc_pkg::dreq_t             tcdm_req_o,
  output logic                      tcdm_valid_o,
  input  logic                      tcdm_ready_i,
  input  cc_pkg::drsp_t             tcdm_rsp_i,
  input  logic                      tcdm_rsp_valid_i,
  output logic                      tcdm_rsp_ready_o,
  output cc_pkg::dreq_t             soc_req_o,
  output logic                      soc_valid_o,
  input  logic                      soc_ready_i,
  input  cc_pkg::drsp_t             soc_rsp_i,
  input  logic                      soc_rsp_valid_i,
  output logic                      soc_rsp_ready_o
);

  import cc_pkg::*;

  acc_req_t     req_q;
  logic         req_q_valid, req_q_ready;
  ssr_cfg_req_t cfg_req;
  logic         cfg_valid, cfg_ready;
  ssr_cfg_rsp_t cfg_rsp;
  logic         cfg_rsp_valid, cfg_rsp_ready;
  acc_rsp_t     arb_rsp;
  logic         arb_valid, arb_ready;

  // Request cut
  cc_spill_reg #(.T(acc_req_t)) i_req_spill (
    .clk_i, .rst_ni,
    .valid_i (acc_req_valid_i), .ready_o (acc_req_ready_o), .data_i (acc_req_i),
    .valid_o (req_q_valid),     .ready_i (req_q_ready),     .data_o (req_q)
  );

  offload_decode i_decode (
    .req_i       (req_q),   .req_valid_i (req_q_valid),     .req_ready_o (req_q_ready),
    .ext_req_o   (ext_req_o), .ext_valid_o (ext_req_valid_o), .ext_ready_i (ext_req_ready_i),
    .cfg_req_o   (cfg_req), .cfg_valid_o (cfg_valid),       .cfg_ready_i (cfg_ready)
  );

  ssr_cfg_regs i_execute (
    .clk_i, .rst_ni,
    .cfg_req_i (cfg_req), .cfg_valid_i (cfg_valid), .cfg_ready_o (cfg_ready),
    .cfg_rsp_o (cfg_rsp), .cfg_rsp_valid_o (cfg_rsp_valid), .cfg_rsp_ready_i (cfg_rsp_ready)
  );

  offload_resp_arbiter i_result (
    .clk_i, .rst_ni,
    .ext_rsp_i (ext_rsp_i), .ext_valid_i (ext_rsp_valid_i), .ext_ready_o (ext_rsp_ready_o),
    .cfg_rsp_i (cfg_rsp),   .cfg_valid_i (cfg_rsp_valid),   .cfg_ready_o (cfg_rsp_ready),
    .rsp_o     (arb_rsp),   .rsp_valid_o (arb_valid),       .rsp_ready_i (arb_ready)
  );

  // Response cut
  cc_spill_reg #(.T(acc_rsp_t)) i_rsp_spill (
    .clk_i, .rst_ni,
    .valid_i (arb_valid),       .ready_o (arb_ready),       .data_i (arb_rsp),
    .valid_o (acc_rsp_valid_o), .ready_i (acc_rsp_ready_i), .data_o (acc_rsp_o)
  );

  data_port_router i_router (
    .clk_i, .rst_ni, .tcdm_base_i,
    .req_i (data_req_i), .req_valid_i (data_req_valid_i), .req_ready_o (data_req_ready_o),
    .rsp_o (data_rsp_o), .rsp_valid_o (data_rsp_valid_o), .rsp_ready_i (data_rsp_ready_i),
    .tcdm_req_o, .tcdm_valid_o, .tcdm_ready_i,
    .tcdm_rsp_i, .tcdm_rsp_valid_i, .tcdm_rsp_ready_o,
    .soc_req_o, .soc_valid_o, .soc_ready_i,
    .soc_rsp_i, .soc_rsp_valid_i, .soc_rsp_ready_o
  );

endmodule

// File: data_port_router.sv
// -------------------------------------
// Data port router
// Sends requests to TCDM or SoC by base
// match, returns responses in order
// -------------------------------------
`timescale 1ns/100ps
`include "cc_consts.svh"

module data_port_router (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`CC_ADDR_WIDTH-1:0] tcdm_base_i,
  input  cc_pkg::dreq_t             req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  output cc_pkg::drsp_t             rsp_o,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output cc_pkg::dreq_t             tcdm_req_o,
  output logic                      tcdm_valid_o,
  input  logic                      tcdm_ready_i,
  input  cc_pkg::drsp_t             tcdm_rsp_i,
  input  logic                      tcdm_rsp_valid_i,
  output logic                      tcdm_rsp_ready_o,
  output cc_pkg::dreq_t             soc_req_o,
  output logic                      soc_valid_o,
  input  logic                      soc_ready_i,
  input  cc_pkg::drsp_t             soc_rsp_i,
  input  logic                      soc_rsp_valid_i,
  output logic                      soc_rsp_ready_o
);

  localparam int unsigned PtrW = $clog2(`CC_ROUTER_DEPTH);
  localparam int unsigned CntW = PtrW + 1;
  localparam logic [`CC_ADDR_WIDTH-1:0] TcdmMask =
    {`CC_ADDR_WIDTH{1'b1}} << `CC_TCDM_ADDR_WIDTH;

  // Destination queue, 1 means TCDM
  logic [`CC_ROUTER_DEPTH-1:0] dest_q;
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic sel_tcdm, full, empty, head, push, pop;

  assign sel_tcdm = (req_i.addr & TcdmMask) == tcdm_base_i;
  assign full     = count_q == CntW'(`CC_ROUTER_DEPTH);
  assign empty    = count_q == '0;
  assign head     = dest_q[rd_ptr_q];

  // ---------------------------------
  // Request path
  // ---------------------------------
  assign tcdm_req_o   = req_i;
  assign soc_req_o    = req_i;
  assign tcdm_valid_o = req_valid_i && sel_tcdm && !full;
  assign soc_valid_o  = req_valid_i && !sel_tcdm && !full;
  assign req_ready_o  = !full && (sel_tcdm ? tcdm_ready_i : soc_ready_i);
  assign push         = req_valid_i && req_ready_o;

  // ---------------------------------
  // Response path
  // ---------------------------------
  assign rsp_o            = head ? tcdm_rsp_i : soc_rsp_i;
  assign rsp_valid_o      = !empty && (head ? tcdm_rsp_valid_i : soc_rsp_valid_i);
  assign tcdm_rsp_ready_o = !empty && head && rsp_ready_i;
  assign soc_rsp_ready_o  = !empty && !head && rsp_ready_i;
  assign pop              = rsp_valid_o && rsp_ready_i;

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) dest_q[wr_ptr_q] <= sel_tcdm;
  end

  a_no_stray_rsp : assert property (@(posedge clk_i) disable iff (rst_ni)
    empty |-> !(tcdm_rsp_valid_i || soc_rsp_valid_i));

endmodule

// File: offload_resp_arbiter.sv
// -------------------------------------
// Offload response arbiter
// Round-robin merge of ext and config
// answers into the core response stream
// -------------------------------------
`timescale 1ns/100ps
`include "cc_consts.svh"

module offload_resp_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  cc_pkg::acc_rsp_t     ext_rsp_i,
  input  logic                 ext_valid_i,
  output logic                 ext_ready_o,
  input  cc_pkg::ssr_cfg_rsp_t cfg_rsp_i,
  input  logic                 cfg_valid_i,
  output logic                 cfg_ready_o,
  output cc_pkg::acc_rsp_t     rsp_o,
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i
);

  // Grant 1 selects the config answer
  logic gnt, gnt_q;
  logic lock_q;
  logic prio_q;

  always_comb begin
    if (lock_q) begin
      gnt = gnt_q;
    end else if (ext_valid_i && cfg_valid_i) begin
      gnt = prio_q;
    end else begin
      gnt = cfg_valid_i;
    end
  end

  assign rsp_valid_o = gnt ? cfg_valid_i : ext_valid_i;
  assign ext_ready_o = rsp_ready_i && !gnt;
  assign cfg_ready_o = rsp_ready_i && gnt;

  always_comb begin
    rsp_o = ext_rsp_i;
    if (gnt) begin
      rsp_o.id    = cfg_rsp_i.id;
      rsp_o.data  = cfg_rsp_i.data;
      rsp_o.error = 1'b0;
    end
  end

  // Stalled output locks the grant, a transfer hands priority over
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      lock_q <= 1'b0;
      gnt_q  <= 1'b0;
      prio_q <= 1'b0;
    end else begin
      lock_q <= rsp_valid_o && !rsp_ready_i;
      gnt_q  <= gnt;
      if (rsp_valid_o && rsp_ready_i) prio_q <= !gnt;
    end
  end

  a_grant_held : assert property (@(posedge clk_i) disable iff (rst_ni)
    (rsp_valid_o && !rsp_ready_i) |=> (gnt == $past(gnt)) && rsp_valid_o && $stable(rsp_o));

endmodule

// File: ssr_cfg_regs.sv
// -------------------------------------
// SSR configuration register file
// Executes reads and writes, holds one
// response until it is taken
// -------------------------------------
`timescale 1ns/100ps
`include "cc_consts.svh"

module ssr_cfg_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  cc_pkg::ssr_cfg_req_t cfg_req_i,
  input  logic                 cfg_valid_i,
  output logic                 cfg_ready_o,
  output cc_pkg::ssr_cfg_rsp_t cfg_rsp_o,
  output logic                 cfg_rsp_valid_o,
  input  logic                 cfg_rsp_ready_i
);

  import cc_pkg::*;

  localparam int unsigned DmW  = $clog2(`CC_NUM_SSRS);
  localparam int unsigned RegW = $clog2(`CC_SSR_NUM_REGS);

  logic [`CC_NUM_SSRS-1:0][`CC_SSR_NUM_REGS-1:0][31:0] regs_q;
  logic [DmW-1:0]  dm_idx;
  logic [RegW-1:0] reg_idx;
  logic            in_range, req_hs;
  logic [31:0]     rdata;
  logic            rsp_valid_q;
  ssr_cfg_rsp_t    rsp_q;

  assign dm_idx   = cfg_req_i.word[DmW-1:0];
  assign reg_idx  = cfg_req_i.word[5 +: RegW];
  assign in_range = (cfg_req_i.word[4:0] < 5'(`CC_NUM_SSRS)) &&
                    (cfg_req_i.word[11:5] < 7'(`CC_SSR_NUM_REGS));
  // Out-of-range words read as zero
  assign rdata    = in_range ? regs_q[dm_idx][reg_idx] : '0;

  // One access in flight at a time
  assign cfg_ready_o = !rsp_valid_q;
  assign req_hs      = cfg_valid_i && cfg_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      regs_q      <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (req_hs && cfg_req_i.write && in_range) begin
        regs_q[dm_idx][reg_idx] <= cfg_req_i.data;
      end
      if (req_hs) begin
        rsp_valid_q <= 1'b1;
      end else if (cfg_rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // Answer carries the value before the access
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      rsp_q.id   <= cfg_req_i.id;
      rsp_q.data <= rdata;
    end
  end

  assign cfg_rsp_o       = rsp_q;
  assign cfg_rsp_valid_o = rsp_valid_q;

  a_one_pending : assert property (@(posedge clk_i) disable iff (rst_ni)
    (cfg_rsp_valid_o && !cfg_rsp_ready_i) |=> (cfg_rsp_valid_o && $stable(cfg_rsp_o)));

endmodule

// File: offload_decode.sv
// -------------------------------------
// Offload decoder
// Steers requests to the ext target or
// the SSR configuration register file
// -------------------------------------
`timescale 1ns/100ps
`include "cc_consts.svh"

module offload_decode (
  input  cc_pkg::acc_req_t     req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output cc_pkg::acc_req_t     ext_req_o,
  output logic                 ext_valid_o,
  input  logic                 ext_ready_i,
  output cc_pkg::ssr_cfg_req_t cfg_req_o,
  output logic                 cfg_valid_o,
  input  logic                 cfg_ready_i
);

  logic        op_ri, op_wi, op_r, op_w;
  logic        cfg_write;
  logic [11:0] cfg_addr;

  // Target 1 is the config register file
  assign ext_req_o   = req_i;
  assign ext_valid_o = req_valid_i && !req_i.addr;
  assign cfg_valid_o = req_valid_i && req_i.addr;
  assign req_ready_o = req_i.addr ? cfg_ready_i : ext_ready_i;

  // ---------------------------------
  // SSR configuration decode
  // ---------------------------------
  assign op_ri = (req_i.data_op & `CC_OP_MASK) == `CC_OP_SCFGRI;
  assign op_wi = (req_i.data_op & `CC_OP_MASK) == `CC_OP_SCFGWI;
  assign op_r  = (req_i.data_op & `CC_OP_MASK) == `CC_OP_SCFGR;
  assign op_w  = (req_i.data_op & `CC_OP_MASK) == `CC_OP_SCFGW;

  // Immediate forms carry the address in imm, register forms in rs2
  always_comb begin
    cfg_addr = '0;
    if (op_ri || op_wi) begin
      cfg_addr = req_i.data_op[31:20];
    end else if (op_r || op_w) begin
      cfg_addr = req_i.data_argb[11:0];
    end
  end

  assign cfg_write = op_w || op_wi;

  always_comb begin
    // Id 0 means no writeback in the core
    cfg_req_o.id    = cfg_write ? '0 : req_i.id;
    // Register index above, data mover index below
    cfg_req_o.word  = {cfg_addr[11:5], cfg_addr[4:0]};
    cfg_req_o.data  = req_i.data_arga;
    cfg_req_o.write = cfg_write;
  end

endmodule

// File: cc_spill_reg.sv
// -------------------------------------
// Spill register
// Two slots, cuts valid, ready and data
// -------------------------------------
`timescale 1ns/100ps
`include "cc_consts.svh"

module cc_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Slot a takes new items, slot b catches a stalled one
  logic a_full_q, b_full_q;
  T     a_data_q, b_data_q;
  logic a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // Older item sits in b whenever b is full
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  a_hold_stable : assert property (@(posedge clk_i) disable iff (rst_ni)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o)));

endmodule

// File: cc_pkg.sv
// -------------------------------------
// Core complex types
// Offload, SSR config and data port payloads
// -------------------------------------
`include "cc_consts.svh"

package cc_pkg;

  // Offload request towards a target
  typedef struct packed {
    logic                    addr;
    logic [`CC_ID_WIDTH-1:0] id;
    logic [31:0]             data_op;
    logic [31:0]             data_arga;
    logic [31:0]             data_argb;
  } acc_req_t;

  // Offload response back to the core
  typedef struct packed {
    logic [`CC_ID_WIDTH-1:0] id;
    logic [31:0]             data;
    logic                    error;
  } acc_rsp_t;

  // Word layout: data mover in 4:0, register above
  typedef struct packed {
    logic [`CC_ID_WIDTH-1:0] id;
    logic [11:0]             word;
    logic [31:0]             data;
    logic                    write;
  } ssr_cfg_req_t;

  typedef struct packed {
    logic [`CC_ID_WIDTH-1:0] id;
    logic [31:0]             data;
  } ssr_cfg_rsp_t;

  // Core data port
  typedef struct packed {
    logic [`CC_ADDR_WIDTH-1:0]   addr;
    logic                        write;
    logic [`CC_DATA_WIDTH-1:0]   data;
    logic [`CC_DATA_WIDTH/8-1:0] strb;
  } dreq_t;

  typedef struct packed {
    logic [`CC_DATA_WIDTH-1:0] data;
    logic                      error;
  } drsp_t;

endpackage

// File: cc_consts.svh
// -------------------------------------
// Core complex constants
// Bus widths, queue depths and the SSR
// configuration opcode patterns
// -------------------------------------
`ifndef CC_CONSTS_SVH
`define CC_CONSTS_SVH

// Bus widths
`define CC_ADDR_WIDTH 32
`define CC_DATA_WIDTH 32
`define CC_TCDM_ADDR_WIDTH 12
`define CC_ID_WIDTH 5

// SSR configuration space
`define CC_NUM_SSRS 2
`define CC_SSR_NUM_REGS 8

// Outstanding data requests in the router
`define CC_ROUTER_DEPTH 4

// Custom-1 opcode, the four forms told apart by funct3
`define CC_OP_MASK   32'h0000_707F
`define CC_OP_SCFGRI 32'h0000_102B
`define CC_OP_SCFGWI 32'h0000_202B
`define CC_OP_SCFGR  32'h0000_302B
`define CC_OP_SCFGW  32'h0000_402B

`endif
